//--- design/seq_pkg.sv
package seq_pkg;

    ////////////////////////////////////////
    // widths
    ////////////////////////////////////////

    localparam int HOST_DATA_WIDTH   = 32; // host write word, narrower fields take the low bits
    localparam int DEF_INDEX_WIDTH   = 2;  // 2 ^ 2 = 4 slots
    localparam int DEF_ADDR_WIDTH    = 32; // src and dst address
    localparam int DEF_SIZE_WIDTH    = 26; // src and dst size
    localparam int DEF_PROFILE_WIDTH = 32; // run counter per slot

    ////////////////////////////////////////
    // sequencer state
    ////////////////////////////////////////

    // one state per slave phase, plus the idle state where the host owns the table
    typedef enum logic [2:0] {
        shutdown = 3'd0, // idle, host may fill and read the table
        reprog   = 3'd1, // slave reprograms from the current slot
        init     = 3'd2, // slave initializes
        trigger  = 3'd3, // ask slave to start executing
        wait_fin = 3'd4  // slave busy until exec_done
    } seq_state_t;

    ////////////////////////////////////////
    // host command
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        cmd_clear    = 2'b00, // stop and zero the slot counter
        cmd_shutdown = 2'b01, // stop, counter kept
        cmd_start    = 2'b10  // run from slot 0, only from shutdown
    } seq_cmd_t;              // 2'b11 is ignored

    ////////////////////////////////////////
    // field select for host writes
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        fld_src_addr = 3'd0,
        fld_src_size = 3'd1,
        fld_dst_addr = 3'd2,
        fld_dst_size = 3'd3,
        fld_profile  = 3'd4  // host may preset the run counter
    } slot_field_t;

endpackage

//--- design/slot_table.sv
module slot_table #(
    parameter int INDEX_WIDTH   = seq_pkg::DEF_INDEX_WIDTH,
    parameter int ADDR_WIDTH    = seq_pkg::DEF_ADDR_WIDTH,
    parameter int SIZE_WIDTH    = seq_pkg::DEF_SIZE_WIDTH,
    parameter int PROFILE_WIDTH = seq_pkg::DEF_PROFILE_WIDTH
) (
    input  logic                                clk,
    input  logic                                reset,
    // write side
    input  logic                                wr_en,    // host write, already gated
    input  logic [INDEX_WIDTH-1:0]              wr_index,
    input  seq_pkg::slot_field_t                wr_field,
    input  logic [seq_pkg::HOST_DATA_WIDTH-1:0] wr_data,
    input  logic                                prof_inc, // bump profile of slot wr_index
    // read side
    input  logic [INDEX_WIDTH-1:0]              rd_index,
    output logic [ADDR_WIDTH-1:0]               src_addr,
    output logic [SIZE_WIDTH-1:0]               src_size,
    output logic [ADDR_WIDTH-1:0]               dst_addr,
    output logic [SIZE_WIDTH-1:0]               dst_size,
    output logic [PROFILE_WIDTH-1:0]            profile
);

    localparam int SLOTS = 1 << INDEX_WIDTH;

    ////////////////////////////////////////
    // slot storage, one array per field
    ////////////////////////////////////////

    logic [ADDR_WIDTH-1:0]    src_addr_mem [SLOTS];
    logic [SIZE_WIDTH-1:0]    src_size_mem [SLOTS];
    logic [ADDR_WIDTH-1:0]    dst_addr_mem [SLOTS];
    logic [SIZE_WIDTH-1:0]    dst_size_mem [SLOTS];
    logic [PROFILE_WIDTH-1:0] prof_mem     [SLOTS];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < SLOTS; i++) begin // whole table reads zero after reset
                src_addr_mem[i] <= '0;
                src_size_mem[i] <= '0;
                dst_addr_mem[i] <= '0;
                dst_size_mem[i] <= '0;
                prof_mem[i]     <= '0;
            end
        end else if (prof_inc) begin
            // only in reprog, host writes are refused then
            prof_mem[wr_index] <= prof_mem[wr_index] + PROFILE_WIDTH'(1);
        end else if (wr_en) begin
            case (wr_field)
                seq_pkg::fld_src_addr: src_addr_mem[wr_index] <= wr_data[ADDR_WIDTH-1:0];
                seq_pkg::fld_src_size: src_size_mem[wr_index] <= wr_data[SIZE_WIDTH-1:0];
                seq_pkg::fld_dst_addr: dst_addr_mem[wr_index] <= wr_data[ADDR_WIDTH-1:0];
                seq_pkg::fld_dst_size: dst_size_mem[wr_index] <= wr_data[SIZE_WIDTH-1:0];
                seq_pkg::fld_profile:  prof_mem[wr_index]     <= wr_data[PROFILE_WIDTH-1:0];
                default: begin
                    // unused select codes write nothing
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // asynchronous read
    ////////////////////////////////////////

    assign src_addr = src_addr_mem[rd_index];
    assign src_size = src_size_mem[rd_index];
    assign dst_addr = dst_addr_mem[rd_index];
    assign dst_size = dst_size_mem[rd_index];
    assign profile  = prof_mem[rd_index];     // pre-increment value during reprog

endmodule

//--- design/seq_control.sv
module seq_control #(
    parameter int INDEX_WIDTH = seq_pkg::DEF_INDEX_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    // host control
    input  seq_pkg::seq_cmd_t      cmd,
    input  logic                   cmd_set,
    input  logic [INDEX_WIDTH-1:0] end_cnt_in,
    input  logic                   end_cnt_set,
    // slave acknowledges, one-cycle pulses
    input  logic                   reprog_ack,
    input  logic                   init_done,
    input  logic                   exec_ack,
    input  logic                   exec_done,
    // status
    output seq_pkg::seq_state_t    state,
    output logic [INDEX_WIDTH-1:0] main_cnt,  // current slot
    output logic [INDEX_WIDTH-1:0] end_cnt,   // last slot of a run
    // slave requests, level for the whole phase
    output logic                   reprog_req,
    output logic                   init_req,
    output logic                   exec_req,
    output logic                   prof_inc   // to the table
);

    logic is_idle;   // host owns the table
    logic do_clear;
    logic do_halt;
    logic do_start;
    logic cmd_hit;   // a command that changes something this cycle
    logic last_slot;

    ////////////////////////////////////////
    // command decoder
    ////////////////////////////////////////

    assign is_idle   = (state == seq_pkg::shutdown);
    assign do_clear  = cmd_set && (cmd == seq_pkg::cmd_clear);
    assign do_halt   = cmd_set && (cmd == seq_pkg::cmd_shutdown);
    assign do_start  = cmd_set && (cmd == seq_pkg::cmd_start) && is_idle; // start ignored while running
    assign cmd_hit   = do_clear || do_halt || do_start;   // ignored codes leave the fsm alone
    assign last_slot = (main_cnt == end_cnt);

    ////////////////////////////////////////
    // sequencer fsm and slot counter
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state    <= seq_pkg::shutdown;
            main_cnt <= '0;
        end else if (cmd_hit) begin
            // host commands win over any ack in the same cycle
            if (do_start) begin
                state    <= seq_pkg::reprog;
                main_cnt <= '0;
            end else begin
                state <= seq_pkg::shutdown;
                if (do_clear) begin
                    main_cnt <= '0;
                end
            end
        end else begin
            case (state)
                seq_pkg::reprog: begin
                    if (reprog_ack) state <= seq_pkg::init;
                end
                seq_pkg::init: begin
                    if (init_done) state <= seq_pkg::trigger;
                end
                seq_pkg::trigger: begin
                    if (exec_ack) state <= seq_pkg::wait_fin;
                end
                seq_pkg::wait_fin: begin
                    if (exec_done) begin
                        if (last_slot) begin          // run complete
                            state    <= seq_pkg::shutdown;
                            main_cnt <= '0;
                        end else begin                // next slot
                            state    <= seq_pkg::reprog;
                            main_cnt <= main_cnt + INDEX_WIDTH'(1);
                        end
                    end
                end
                default: begin
                    // shutdown waits for a start
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // end count, host loads it while idle
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            end_cnt <= '0;
        end else if (end_cnt_set && is_idle) begin
            end_cnt <= end_cnt_in;
        end
    end

    // requests straight from the state
    assign reprog_req = (state == seq_pkg::reprog);
    assign init_req   = (state == seq_pkg::init);
    assign exec_req   = (state == seq_pkg::trigger);

    // once per visit, on the edge that leaves reprog
    assign prof_inc = reprog_req && reprog_ack && !cmd_hit;

endmodule

//--- design/host_port.sv
module host_port #(
    parameter int INDEX_WIDTH = seq_pkg::DEF_INDEX_WIDTH
) (
    input  seq_pkg::seq_state_t    state,
    input  logic [INDEX_WIDTH-1:0] main_cnt,  // slot the sequencer is on
    // host write request
    input  logic [INDEX_WIDTH-1:0] wr_index,
    input  logic                   wr_set,
    // host read request
    input  logic [INDEX_WIDTH-1:0] rd_index,
    input  logic                   rd_req,
    // host side answers
    output logic                   wr_accept,
    output logic                   rd_ready,
    // table side
    output logic [INDEX_WIDTH-1:0] tbl_index, // shared write and read index
    output logic                   tbl_wr_en
);

    logic                   host_owns;   // table belongs to the host
    logic [INDEX_WIDTH-1:0] host_index;

    ////////////////////////////////////////
    // table ownership
    ////////////////////////////////////////

    assign host_owns = (state == seq_pkg::shutdown);

    // one index into the table, a host write takes it over a host read
    assign host_index = wr_set ? wr_index : rd_index;

    // while running the slave sees the current slot
    assign tbl_index = host_owns ? host_index : main_cnt;

    ////////////////////////////////////////
    // host strobes
    ////////////////////////////////////////

    assign tbl_wr_en = host_owns && wr_set; // refused during a run
    assign wr_accept = tbl_wr_en;            // same cycle as the table write
    assign rd_ready  = host_owns && rd_req;  // low whenever the sequencer runs

endmodule

//--- design/magic_seq_top.sv
module magic_seq_top #(
    parameter int INDEX_WIDTH   = seq_pkg::DEF_INDEX_WIDTH,
    parameter int ADDR_WIDTH    = seq_pkg::DEF_ADDR_WIDTH,
    parameter int SIZE_WIDTH    = seq_pkg::DEF_SIZE_WIDTH,
    parameter int PROFILE_WIDTH = seq_pkg::DEF_PROFILE_WIDTH
) (
    input  logic                                clk,
    input  logic                                reset,
    // host table write
    input  logic [INDEX_WIDTH-1:0]              wr_index,
    input  seq_pkg::slot_field_t                wr_field,
    input  logic [seq_pkg::HOST_DATA_WIDTH-1:0] wr_data,
    input  logic                                wr_set,
    output logic                                wr_accept,
    // host table read
    input  logic [INDEX_WIDTH-1:0]              rd_index,
    input  logic                                rd_req,
    output logic                                rd_ready,
    // host control
    input  seq_pkg::seq_cmd_t                   cmd,
    input  logic                                cmd_set,
    input  logic [INDEX_WIDTH-1:0]              end_cnt_in,
    input  logic                                end_cnt_set,
    output seq_pkg::seq_state_t                 state,
    output logic [INDEX_WIDTH-1:0]              main_cnt,
    output logic [INDEX_WIDTH-1:0]              end_cnt,
    // slave dma handshake
    output logic                                reprog_req,
    input  logic                                reprog_ack,
    output logic                                init_req,
    input  logic                                init_done,
    output logic                                exec_req,
    input  logic                                exec_ack,
    input  logic                                exec_done,
    // slot fields, shared by host read and slave
    output logic [ADDR_WIDTH-1:0]               src_addr,
    output logic [SIZE_WIDTH-1:0]               src_size,
    output logic [ADDR_WIDTH-1:0]               dst_addr,
    output logic [SIZE_WIDTH-1:0]               dst_size,
    output logic [PROFILE_WIDTH-1:0]            profile
);

    logic [INDEX_WIDTH-1:0] tbl_index; // host index in shutdown, main_cnt otherwise
    logic                   tbl_wr_en;
    logic                   prof_inc;

    ////////////////////////////////////////
    // sequencer
    ////////////////////////////////////////

    seq_control #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_ctrl (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .cmd_set     (cmd_set),
        .end_cnt_in  (end_cnt_in),
        .end_cnt_set (end_cnt_set),
        .reprog_ack  (reprog_ack),
        .init_done   (init_done),
        .exec_ack    (exec_ack),
        .exec_done   (exec_done),
        .state       (state),
        .main_cnt    (main_cnt),
        .end_cnt     (end_cnt),
        .reprog_req  (reprog_req),
        .init_req    (init_req),
        .exec_req    (exec_req),
        .prof_inc    (prof_inc)
    );

    ////////////////////////////////////////
    // host access arbitration
    ////////////////////////////////////////

    host_port #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_host (
        .state       (state),
        .main_cnt    (main_cnt),
        .wr_index    (wr_index),
        .wr_set      (wr_set),
        .rd_index    (rd_index),
        .rd_req      (rd_req),
        .wr_accept   (wr_accept),
        .rd_ready    (rd_ready),
        .tbl_index   (tbl_index),
        .tbl_wr_en   (tbl_wr_en)
    );

    ////////////////////////////////////////
    // slot table
    ////////////////////////////////////////

    slot_table #(
        .INDEX_WIDTH   (INDEX_WIDTH),
        .ADDR_WIDTH    (ADDR_WIDTH),
        .SIZE_WIDTH    (SIZE_WIDTH),
        .PROFILE_WIDTH (PROFILE_WIDTH)
    ) u_table (
        .clk      (clk),
        .reset    (reset),
        .wr_en    (tbl_wr_en),
        .wr_index (tbl_index),  // one shared index for writes and reads
        .wr_field (wr_field),
        .wr_data  (wr_data),
        .prof_inc (prof_inc),
        .rd_index (tbl_index),
        .src_addr (src_addr),
        .src_size (src_size),
        .dst_addr (dst_addr),
        .dst_size (dst_size),
        .profile  (profile)
    );

endmodule

//--- dv/tb_magic_seq.sv
module tb_magic_seq;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IW    = seq_pkg::DEF_INDEX_WIDTH;
    localparam int AW    = seq_pkg::DEF_ADDR_WIDTH;
    localparam int SW    = seq_pkg::DEF_SIZE_WIDTH;
    localparam int PW    = seq_pkg::DEF_PROFILE_WIDTH;
    localparam int WW    = 2 * AW + 2 * SW + PW; // one slot as a flat word
    localparam int SLOTS = 1 << IW;
    // 8 visits x 4 phases x 5 cycles at the slowest slave, plus ~200 cycles of host traffic,
    // with a wide margin on top
    localparam int WATCHDOG_CYCLES = 3000;

    logic                                clk, reset;
    logic [IW-1:0]                       wr_index, rd_index, end_cnt_in, main_cnt, end_cnt;
    seq_pkg::slot_field_t                wr_field;
    logic [seq_pkg::HOST_DATA_WIDTH-1:0] wr_data;
    logic                                wr_set, wr_accept, rd_req, rd_ready;
    seq_pkg::seq_cmd_t                   cmd;
    logic                                cmd_set, end_cnt_set;
    seq_pkg::seq_state_t                 state;
    logic                                reprog_req, init_req, exec_req;
    logic                                reprog_ack, init_done, exec_ack, exec_done;
    logic [AW-1:0]                       src_addr, dst_addr;
    logic [SW-1:0]                       src_size, dst_size;
    logic [PW-1:0]                       profile;

    // model of the table
    logic [AW-1:0] m_src_addr [SLOTS];
    logic [SW-1:0] m_src_size [SLOTS];
    logic [AW-1:0] m_dst_addr [SLOTS];
    logic [SW-1:0] m_dst_size [SLOTS];
    logic [PW-1:0] m_prof     [SLOTS];
    logic [IW-1:0] m_end;

    logic [IW-1:0] exp_slot   [$]; // slots the next run should visit, in order
    logic [IW-1:0] visit_slot [$]; // slot index seen by the slave at each reprog
    logic [WW-1:0] visit_word [$]; // fields seen with it
    event          visit_logged;

    integer seed = 32'hfa973109;
    int     errors, checks, tests_run, err_base;
    string  cur_test;

    magic_seq_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [WW-1:0] ref_slot(input logic [IW-1:0] s);
        return {m_src_addr[s], m_src_size[s], m_dst_addr[s], m_dst_size[s], m_prof[s]};
    endfunction

    // slave sees the old profile, the visit then counts once
    function automatic logic [WW-1:0] ref_visit(input logic [IW-1:0] s);
        logic [WW-1:0] w;
        w = ref_slot(s);
        m_prof[s] = m_prof[s] + 1;
        return w;
    endfunction

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_slot(input string what, input logic [WW-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_state(input string what, input seq_pkg::seq_state_t exp, act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch [%s] %s: expected %s, actual %s", cur_test, what,
                     exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_cnt(input string what, input logic [IW-1:0] exp, act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch [%s] %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string what, input logic exp, act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // no slave phase is requested while the sequencer is shut down
    task automatic reqs_idle();
        check_flag("reprog_req", 1'b0, reprog_req);
        check_flag("init_req", 1'b0, init_req);
        check_flag("exec_req", 1'b0, exec_req);
    endtask

    task automatic visits_done();
        checks++;
        if (exp_slot.size() != 0) begin
            $display("[%s] run ended before the slave saw %0d more slot(s)", cur_test,
                     exp_slot.size());
            errors++;
        end
        exp_slot.delete();
    endtask

    ////////////////////////////////////////
    // host side helpers
    ////////////////////////////////////////

    task automatic host_write(input logic [IW-1:0] s, input seq_pkg::slot_field_t fld,
                              input logic [31:0] data, input logic exp_acc);
        @(posedge clk);
        wr_set   <= 1'b1;
        wr_index <= s;
        wr_field <= fld;
        wr_data  <= data;
        @(negedge clk);
        check_flag("wr_accept", exp_acc, wr_accept);
        if (exp_acc) begin
            case (fld) // narrow fields keep the low bits
                seq_pkg::fld_src_addr: m_src_addr[s] = data[AW-1:0];
                seq_pkg::fld_src_size: m_src_size[s] = data[SW-1:0];
                seq_pkg::fld_dst_addr: m_dst_addr[s] = data[AW-1:0];
                seq_pkg::fld_dst_size: m_dst_size[s] = data[SW-1:0];
                seq_pkg::fld_profile:  m_prof[s]     = data[PW-1:0];
                default: ;
            endcase
        end
        @(posedge clk);
        wr_set <= 1'b0;
    endtask

    task automatic host_read(input logic [IW-1:0] s, input logic exp_ready);
        @(posedge clk);
        rd_req   <= 1'b1;
        rd_index <= s;
        @(negedge clk);
        check_flag("rd_ready", exp_ready, rd_ready);
        if (exp_ready)
            check_slot($sformatf("slot %0d", s), ref_slot(s),
                       {src_addr, src_size, dst_addr, dst_size, profile});
        @(posedge clk);
        rd_req <= 1'b0;
    endtask

    task automatic set_end(input logic [IW-1:0] v);
        @(posedge clk);
        end_cnt_in  <= v;
        end_cnt_set <= 1'b1;
        @(posedge clk);
        end_cnt_set <= 1'b0;
    endtask

    // returns on the edge that samples the command
    task automatic run_cmd(input seq_pkg::seq_cmd_t c);
        @(posedge clk);
        cmd     <= c;
        cmd_set <= 1'b1;
        @(posedge clk);
        cmd_set <= 1'b0;
    endtask

    // the run ends at the edge that samples exec_done of slot end_cnt
    task automatic wait_run_end();
        do @(negedge clk); while (!(exec_done && main_cnt == m_end));
        @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = errors;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %0d %s: %s", tests_run, cur_test, (errors == err_base) ? "pass" : "FAIL");
    endtask

    ////////////////////////////////////////
    // slave dma responder
    ////////////////////////////////////////

    initial begin : slave_dma
        seq_pkg::seq_state_t phase;
        int                  dly;
        {reprog_ack, init_done, exec_ack, exec_done} <= 4'b0;
        forever begin
            @(negedge clk);
            if (int'(reprog_req) + int'(init_req) + int'(exec_req) > 1) begin
                $display("[%s] more than one slave request high at once", cur_test);
                errors++;
            end
            if (reprog_req)
                phase = seq_pkg::reprog;
            else if (init_req)
                phase = seq_pkg::init;
            else if (exec_req)
                phase = seq_pkg::trigger;
            else
                phase = seq_pkg::shutdown; // nothing requested
            if (phase != seq_pkg::shutdown) begin
                if (phase == seq_pkg::reprog) begin // new visit, log what the slave is given
                    visit_slot.push_back(main_cnt);
                    visit_word.push_back({src_addr, src_size, dst_addr, dst_size, profile});
                    -> visit_logged;
                end
                dly = 1 + (($random(seed) & 32'h7fff_ffff) % 4); // 1 to 4 cycles
                repeat (dly) @(posedge clk);
                case (phase)
                    seq_pkg::reprog: reprog_ack <= 1'b1;
                    seq_pkg::init:   init_done  <= 1'b1;
                    default:         exec_ack   <= 1'b1;
                endcase
                @(posedge clk);
                {reprog_ack, init_done, exec_ack, exec_done} <= 4'b0; // one-cycle pulse
                if (phase == seq_pkg::trigger) begin // executing now, finish later
                    dly = 1 + (($random(seed) & 32'h7fff_ffff) % 4);
                    repeat (dly) @(posedge clk);
                    exec_done <= 1'b1;
                    @(posedge clk);
                    exec_done <= 1'b0;
                end
            end
        end
    end

    // each logged visit against the model, in order
    initial begin : compare_visits
        logic [IW-1:0] s;
        logic [IW-1:0] e;
        logic [WW-1:0] w;
        forever begin
            @(visit_logged);
            while (visit_slot.size() != 0) begin
                s = visit_slot.pop_front();
                w = visit_word.pop_front();
                if (exp_slot.size() == 0) begin
                    $display("[%s] slave was given slot %0d that no run should visit",
                             cur_test, s);
                    errors++;
                end else begin
                    e = exp_slot.pop_front();
                    check_cnt("visit slot", e, s);
                    check_slot("visit fields", ref_visit(e), w);
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog: run still busy after %0d cycles, %s", WATCHDOG_CYCLES, cur_test);
        $display("ERRORS FOUND");
        $finish;
    end

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    initial begin : tests
        for (int s = 0; s < SLOTS; s++) begin // table is zero after reset
            m_src_addr[s] = '0;
            m_src_size[s] = '0;
            m_dst_addr[s] = '0;
            m_dst_size[s] = '0;
            m_prof[s]     = '0;
        end
        m_end = '0;
        {wr_set, rd_req, cmd_set, end_cnt_set} <= 4'b0;
        {wr_index, rd_index, end_cnt_in} <= '0;
        wr_field <= seq_pkg::fld_src_addr;
        wr_data  <= '0;
        cmd      <= seq_pkg::cmd_clear;
        reset    <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b1;

        begin_test("table write and readback");
        for (int s = 0; s < SLOTS; s++)
            for (int f = 0; f < 5; f++)
                host_write(s, seq_pkg::slot_field_t'(f), $random(seed), 1'b1);
        for (int s = 0; s < SLOTS; s++)
            host_read(s, 1'b1);
        @(negedge clk);
        check_flag("rd_ready without rd_req", 1'b0, rd_ready);
        end_test();

        begin_test("run over slots 0 to 2");
        set_end(2);
        m_end = 2;
        for (int s = 0; s <= 2; s++)
            exp_slot.push_back(s);
        run_cmd(seq_pkg::cmd_start);
        wait_run_end();
        check_state("state after run", seq_pkg::shutdown, state);
        check_cnt("main_cnt after run", 0, main_cnt);
        check_cnt("end_cnt", m_end, end_cnt);
        reqs_idle();
        visits_done();
        for (int s = 0; s < SLOTS; s++) // visited profiles up by one, slot 3 untouched
            host_read(s, 1'b1);
        end_test();

        begin_test("host access refused during a run");
        set_end(1);
        m_end = 1;
        exp_slot.push_back(0);
        exp_slot.push_back(1);
        run_cmd(seq_pkg::cmd_start);
        host_write(3, seq_pkg::fld_src_addr, 32'hdead_beef, 1'b0);
        host_read(3, 1'b0);
        set_end(3); // ignored, m_end kept
        wait_run_end();
        check_cnt("end_cnt", m_end, end_cnt);
        visits_done();
        for (int s = 0; s < SLOTS; s++)
            host_read(s, 1'b1);
        end_test();

        begin_test("shutdown and clear mid-run");
        set_end(3);
        m_end = 3;
        exp_slot.push_back(0);
        exp_slot.push_back(1);
        run_cmd(seq_pkg::cmd_start);
        // slot 1 already past reprog, so its profile has counted
        do @(negedge clk); while (!(state == seq_pkg::trigger && main_cnt == 1));
        run_cmd(seq_pkg::cmd_shutdown);
        @(negedge clk);
        check_state("state after shutdown", seq_pkg::shutdown, state);
        check_cnt("main_cnt after shutdown", 1, main_cnt);
        reqs_idle();
        run_cmd(seq_pkg::cmd_clear);
        @(negedge clk);
        check_state("state after clear", seq_pkg::shutdown, state);
        check_cnt("main_cnt after clear", 0, main_cnt);
        visits_done();
        end_test();

        begin_test("start while running, end count 0");
        repeat (6) @(posedge clk); // late slave pulses from the aborted run die out
        set_end(0);
        m_end = 0;
        exp_slot.push_back(0);
        run_cmd(seq_pkg::cmd_start);
        do @(negedge clk); while (state != seq_pkg::init);
        run_cmd(seq_pkg::cmd_start); // a restart would show as a second visit
        wait_run_end();
        check_cnt("end_cnt", m_end, end_cnt);
        check_cnt("main_cnt after run", 0, main_cnt);
        visits_done();
        for (int s = 0; s < SLOTS; s++)
            host_read(s, 1'b1);
        end_test();

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/seq_pkg.sv
design/slot_table.sv
design/seq_control.sv
design/host_port.sv
design/magic_seq_top.sv
dv/tb_magic_seq.sv
